//--- board_pkg.sv
// Widths and encodings for the board glue; the command words assume an UltraScale ICAP
`default_nettype none

package board_pkg;

    // Pad bus widths
    localparam int flash_dq_width = 16;
    localparam int flash_addr_width = 23;
    localparam int icap_word_width = 32;

    // Synchronizer depths
    localparam int sync_stages_default = 2;
    localparam int boot_sync_stages_default = 3;

    // Reprogram command stream words, before per-byte bit reversal
    typedef enum logic [icap_word_width-1:0] {
        word_dummy = 32'hffff_ffff,
        word_sync = 32'haa99_5566,
        word_noop = 32'h2000_0000,
        // Type 1 write of one word to CMD
        word_cmd_write = 32'h3000_8001,
        word_iprog = 32'h0000_000f
    } icap_word_e;

    typedef enum logic [2:0] {
        st_idle,
        st_sync,
        st_noop_a,
        st_cmd,
        st_iprog,
        st_noop_b
    } icap_state_e;

endpackage

`default_nettype wire

//--- sync_signal_bank.sv
// No reset on the stages; each bit is resynchronized on its own, so a multi-bit value may skew
`default_nettype none

module sync_signal_bank #(
    parameter int WIDTH = 1,
    parameter int SYNC_STAGES = board_pkg::sync_stages_default
) (
    input  wire              pcie_user_clk,
    input  wire  [WIDTH-1:0] in_i,
    output logic [WIDTH-1:0] out_o
);

    logic [WIDTH-1:0] stage_q [SYNC_STAGES];

    always_ff @(posedge pcie_user_clk) begin
        stage_q[0] <= in_i;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    assign out_o = stage_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- icap_reboot_seq.sv
// Needs BOOT_SYNC_STAGES >= 2; icap_avail_i is used unsynchronized, keep it on pcie_user_clk
`default_nettype none

module icap_reboot_seq #(
    parameter int BOOT_SYNC_STAGES = board_pkg::boot_sync_stages_default
) (
    input  wire                                   pcie_user_clk,
    input  wire                                   rst_i,
    input  wire                                   boot_req_i,
    input  wire                                   icap_avail_i,
    output logic                                  icap_csib_o,
    output logic                                  icap_rdwrb_o,
    output logic [board_pkg::icap_word_width-1:0] icap_data_o
);

    import board_pkg::*;

    logic [BOOT_SYNC_STAGES-1:0] boot_sync_q;
    logic boot_req_sync;
    logic start;
    icap_state_e state_q;
    icap_word_e word_q;
    logic csib_q;

    always_ff @(posedge pcie_user_clk) begin
        if (rst_i) begin
            boot_sync_q <= '0;
        end else begin
            boot_sync_q <= {boot_sync_q[BOOT_SYNC_STAGES-2:0], boot_req_i};
        end
    end

    assign boot_req_sync = boot_sync_q[BOOT_SYNC_STAGES-1];
    assign start = boot_req_sync && icap_avail_i;

    // One command word per cycle, chip select low through the whole stream
    always_ff @(posedge pcie_user_clk) begin
        if (rst_i) begin
            state_q <= st_idle;
            csib_q <= 1'b1;
            word_q <= word_dummy;
        end else begin
            csib_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    word_q <= word_dummy;
                    csib_q <= !start;
                    if (start) begin
                        state_q <= st_sync;
                    end
                end
                st_sync: begin
                    word_q <= word_sync;
                    state_q <= st_noop_a;
                end
                st_noop_a: begin
                    word_q <= word_noop;
                    state_q <= st_cmd;
                end
                st_cmd: begin
                    word_q <= word_cmd_write;
                    state_q <= st_iprog;
                end
                st_iprog: begin
                    word_q <= word_iprog;
                    state_q <= st_noop_b;
                end
                st_noop_b: begin
                    // Back to idle; a held request restarts with no gap
                    word_q <= word_noop;
                    state_q <= st_idle;
                end
                default: begin
                    word_q <= word_dummy;
                    csib_q <= 1'b1;
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // ICAP takes each byte MSB first
    always_comb begin
        for (int b = 0; b < icap_word_width / 8; b++) begin
            for (int j = 0; j < 8; j++) begin
                icap_data_o[8*b + j] = word_q[8*b + 7 - j];
            end
        end
    end

    assign icap_csib_o = csib_q;
    // Write-only port
    assign icap_rdwrb_o = 1'b0;

endmodule

`default_nettype wire

//--- flash_pin_stage.sv
// Tristate pads are split into value and enable; the flash data input is not reset
`default_nettype none

module flash_pin_stage #(
    parameter int SYNC_STAGES = board_pkg::sync_stages_default
) (
    input  wire                                    pcie_user_clk,
    input  wire                                    rst_i,
    input  wire  [board_pkg::flash_dq_width-1:0]   flash_dq_i,
    input  wire                                    flash_dq_oe_i,
    input  wire  [board_pkg::flash_addr_width-1:0] flash_addr_i,
    input  wire                                    flash_region_i,
    input  wire                                    flash_region_oe_i,
    input  wire                                    flash_ce_n_i,
    input  wire                                    flash_oe_n_i,
    input  wire                                    flash_we_n_i,
    input  wire                                    flash_adv_n_i,
    input  wire  [board_pkg::flash_dq_width-1:0]   flash_dq_pad_i,
    output logic [board_pkg::flash_dq_width-1:0]   flash_dq_pad_o,
    output logic                                   flash_dq_oe_o,
    output logic [board_pkg::flash_addr_width-1:0] flash_addr_o,
    output logic                                   flash_region_o,
    output logic                                   flash_region_oe_o,
    output logic                                   flash_ce_n_o,
    output logic                                   flash_oe_n_o,
    output logic                                   flash_we_n_o,
    output logic                                   flash_adv_n_o,
    output logic [board_pkg::flash_dq_width-1:0]   flash_dq_o
);

    import board_pkg::*;

    // Strobes idle high, drivers off
    always_ff @(posedge pcie_user_clk) begin
        if (rst_i) begin
            flash_dq_oe_o <= 1'b0;
            flash_region_oe_o <= 1'b0;
            flash_ce_n_o <= 1'b1;
            flash_oe_n_o <= 1'b1;
            flash_we_n_o <= 1'b1;
            flash_adv_n_o <= 1'b1;
        end else begin
            flash_dq_oe_o <= flash_dq_oe_i;
            flash_region_oe_o <= flash_region_oe_i;
            flash_ce_n_o <= flash_ce_n_i;
            flash_oe_n_o <= flash_oe_n_i;
            flash_we_n_o <= flash_we_n_i;
            flash_adv_n_o <= flash_adv_n_i;
        end
    end

    always_ff @(posedge pcie_user_clk) begin
        flash_dq_pad_o <= flash_dq_i;
        flash_addr_o <= flash_addr_i;
        flash_region_o <= flash_region_i;
    end

    sync_signal_bank #(
        .WIDTH(flash_dq_width),
        .SYNC_STAGES(SYNC_STAGES)
    ) u_dq_sync (
        .pcie_user_clk(pcie_user_clk),
        .in_i(flash_dq_pad_i),
        .out_o(flash_dq_o)
    );

endmodule

`default_nettype wire

//--- sfp_i2c_pin_stage.sv
// Open-drain lines: *_t high releases the pad; drive values are not reset
`default_nettype none

module sfp_i2c_pin_stage #(
    parameter int SYNC_STAGES = board_pkg::sync_stages_default
) (
    input  wire  pcie_user_clk,
    input  wire  rst_i,
    input  wire  scl_sfp_o_i,
    input  wire  scl_sfp_t_i,
    output logic scl_sfp_pad_o,
    output logic scl_sfp_pad_t_o,
    input  wire  scl_sfp_pad_i,
    output logic scl_sfp_sync_o,
    input  wire  sda_sfp1_o_i,
    input  wire  sda_sfp1_t_i,
    output logic sda_sfp1_pad_o,
    output logic sda_sfp1_pad_t_o,
    input  wire  sda_sfp1_pad_i,
    output logic sda_sfp1_sync_o,
    input  wire  sda_sfp2_o_i,
    input  wire  sda_sfp2_t_i,
    output logic sda_sfp2_pad_o,
    output logic sda_sfp2_pad_t_o,
    input  wire  sda_sfp2_pad_i,
    output logic sda_sfp2_sync_o,
    input  wire  scl_eeprom_o_i,
    input  wire  scl_eeprom_t_i,
    output logic scl_eeprom_pad_o,
    output logic scl_eeprom_pad_t_o,
    input  wire  scl_eeprom_pad_i,
    output logic scl_eeprom_sync_o,
    input  wire  sda_eeprom_o_i,
    input  wire  sda_eeprom_t_i,
    output logic sda_eeprom_pad_o,
    output logic sda_eeprom_pad_t_o,
    input  wire  sda_eeprom_pad_i,
    output logic sda_eeprom_sync_o,
    input  wire  sfp1_npres_i,
    input  wire  sfp2_npres_i,
    input  wire  sfp1_los_i,
    input  wire  sfp2_los_i,
    output logic sfp1_npres_sync_o,
    output logic sfp2_npres_sync_o,
    output logic sfp1_los_sync_o,
    output logic sfp2_los_sync_o
);

    localparam int sync_width = 9;

    always_ff @(posedge pcie_user_clk) begin
        if (rst_i) begin
            {scl_sfp_pad_t_o, sda_sfp1_pad_t_o, sda_sfp2_pad_t_o} <= 3'b111;
            {scl_eeprom_pad_t_o, sda_eeprom_pad_t_o} <= 2'b11;
        end else begin
            {scl_sfp_pad_t_o, sda_sfp1_pad_t_o, sda_sfp2_pad_t_o} <=
                {scl_sfp_t_i, sda_sfp1_t_i, sda_sfp2_t_i};
            {scl_eeprom_pad_t_o, sda_eeprom_pad_t_o} <= {scl_eeprom_t_i, sda_eeprom_t_i};
        end
    end

    always_ff @(posedge pcie_user_clk) begin
        {scl_sfp_pad_o, sda_sfp1_pad_o, sda_sfp2_pad_o} <=
            {scl_sfp_o_i, sda_sfp1_o_i, sda_sfp2_o_i};
        {scl_eeprom_pad_o, sda_eeprom_pad_o} <= {scl_eeprom_o_i, sda_eeprom_o_i};
    end

    // Status lines and bus levels share one bank
    sync_signal_bank #(
        .WIDTH(sync_width),
        .SYNC_STAGES(SYNC_STAGES)
    ) u_in_sync (
        .pcie_user_clk(pcie_user_clk),
        .in_i({sfp1_npres_i, sfp2_npres_i, sfp1_los_i, sfp2_los_i,
            scl_sfp_pad_i, sda_sfp1_pad_i, sda_sfp2_pad_i,
            scl_eeprom_pad_i, sda_eeprom_pad_i}),
        .out_o({sfp1_npres_sync_o, sfp2_npres_sync_o, sfp1_los_sync_o, sfp2_los_sync_o,
            scl_sfp_sync_o, sda_sfp1_sync_o, sda_sfp2_sync_o,
            scl_eeprom_sync_o, sda_eeprom_sync_o})
    );

endmodule

`default_nettype wire

//--- board_glue_top.sv
// Everything runs on pcie_user_clk; pads are split value/enable ports, tristate buffers sit outside
`default_nettype none

module board_glue_top #(
    parameter int SYNC_STAGES = board_pkg::sync_stages_default,
    parameter int BOOT_SYNC_STAGES = board_pkg::boot_sync_stages_default
) (
    input  wire                                    pcie_user_clk,
    input  wire                                    rst_i,
    // Reboot
    input  wire                                    boot_req_i,
    input  wire                                    icap_avail_i,
    output logic                                   icap_csib_o,
    output logic                                   icap_rdwrb_o,
    output logic [board_pkg::icap_word_width-1:0]  icap_data_o,
    // Flash
    input  wire  [board_pkg::flash_dq_width-1:0]   flash_dq_i,
    input  wire                                    flash_dq_oe_i,
    input  wire  [board_pkg::flash_addr_width-1:0] flash_addr_i,
    input  wire                                    flash_region_i,
    input  wire                                    flash_region_oe_i,
    input  wire                                    flash_ce_n_i,
    input  wire                                    flash_oe_n_i,
    input  wire                                    flash_we_n_i,
    input  wire                                    flash_adv_n_i,
    input  wire  [board_pkg::flash_dq_width-1:0]   flash_dq_pad_i,
    output logic [board_pkg::flash_dq_width-1:0]   flash_dq_pad_o,
    output logic                                   flash_dq_oe_o,
    output logic [board_pkg::flash_addr_width-1:0] flash_addr_o,
    output logic                                   flash_region_o,
    output logic                                   flash_region_oe_o,
    output logic                                   flash_ce_n_o,
    output logic                                   flash_oe_n_o,
    output logic                                   flash_we_n_o,
    output logic                                   flash_adv_n_o,
    output logic [board_pkg::flash_dq_width-1:0]   flash_dq_o,
    // Two-wire buses
    input  wire                                    scl_sfp_o_i,
    input  wire                                    scl_sfp_t_i,
    output logic                                   scl_sfp_pad_o,
    output logic                                   scl_sfp_pad_t_o,
    input  wire                                    scl_sfp_pad_i,
    output logic                                   scl_sfp_sync_o,
    input  wire                                    sda_sfp1_o_i,
    input  wire                                    sda_sfp1_t_i,
    output logic                                   sda_sfp1_pad_o,
    output logic                                   sda_sfp1_pad_t_o,
    input  wire                                    sda_sfp1_pad_i,
    output logic                                   sda_sfp1_sync_o,
    input  wire                                    sda_sfp2_o_i,
    input  wire                                    sda_sfp2_t_i,
    output logic                                   sda_sfp2_pad_o,
    output logic                                   sda_sfp2_pad_t_o,
    input  wire                                    sda_sfp2_pad_i,
    output logic                                   sda_sfp2_sync_o,
    input  wire                                    scl_eeprom_o_i,
    input  wire                                    scl_eeprom_t_i,
    output logic                                   scl_eeprom_pad_o,
    output logic                                   scl_eeprom_pad_t_o,
    input  wire                                    scl_eeprom_pad_i,
    output logic                                   scl_eeprom_sync_o,
    input  wire                                    sda_eeprom_o_i,
    input  wire                                    sda_eeprom_t_i,
    output logic                                   sda_eeprom_pad_o,
    output logic                                   sda_eeprom_pad_t_o,
    input  wire                                    sda_eeprom_pad_i,
    output logic                                   sda_eeprom_sync_o,
    // SFP status
    input  wire                                    sfp1_npres_i,
    input  wire                                    sfp2_npres_i,
    input  wire                                    sfp1_los_i,
    input  wire                                    sfp2_los_i,
    output logic                                   sfp1_npres_sync_o,
    output logic                                   sfp2_npres_sync_o,
    output logic                                   sfp1_los_sync_o,
    output logic                                   sfp2_los_sync_o
);

    // Port names match the children one to one
    icap_reboot_seq #(
        .BOOT_SYNC_STAGES(BOOT_SYNC_STAGES)
    ) u_reboot (.*);

    flash_pin_stage #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_flash (.*);

    sfp_i2c_pin_stage #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_i2c (.*);

endmodule

`default_nettype wire

//--- tb_board_glue.sv
// Latencies checked here assume SYNC_STAGES 2 and BOOT_SYNC_STAGES 3, the top level defaults
`default_nettype none

module tb_board_glue;

    localparam int clk_period = 8;
    localparam int reset_cycles = 16;
    localparam int random_cycles = 200;
    localparam int boot_cycles = 32;
    // Reset, random phase and two boot runs, with a wide margin
    localparam int timeout_cycles = 4 * (reset_cycles + random_cycles + 2 * boot_cycles);

    logic pcie_user_clk = 1'b0;
    logic rst_i, boot_req_i, icap_avail_i;
    logic icap_csib_o, icap_rdwrb_o;
    logic [31:0] icap_data_o;
    logic [15:0] flash_dq_i, flash_dq_pad_i, flash_dq_pad_o, flash_dq_o;
    logic [22:0] flash_addr_i, flash_addr_o;
    logic flash_dq_oe_i, flash_region_i, flash_region_oe_i;
    logic flash_ce_n_i, flash_oe_n_i, flash_we_n_i, flash_adv_n_i;
    logic flash_dq_oe_o, flash_region_o, flash_region_oe_o;
    logic flash_ce_n_o, flash_oe_n_o, flash_we_n_o, flash_adv_n_o;
    logic scl_sfp_o_i, sda_sfp1_o_i, sda_sfp2_o_i, scl_eeprom_o_i, sda_eeprom_o_i;
    logic scl_sfp_t_i, sda_sfp1_t_i, sda_sfp2_t_i, scl_eeprom_t_i, sda_eeprom_t_i;
    logic scl_sfp_pad_o, sda_sfp1_pad_o, sda_sfp2_pad_o, scl_eeprom_pad_o, sda_eeprom_pad_o;
    logic scl_sfp_pad_t_o, sda_sfp1_pad_t_o, sda_sfp2_pad_t_o;
    logic scl_eeprom_pad_t_o, sda_eeprom_pad_t_o;
    logic scl_sfp_pad_i, sda_sfp1_pad_i, sda_sfp2_pad_i, scl_eeprom_pad_i, sda_eeprom_pad_i;
    logic scl_sfp_sync_o, sda_sfp1_sync_o, sda_sfp2_sync_o;
    logic scl_eeprom_sync_o, sda_eeprom_sync_o;
    logic sfp1_npres_i, sfp2_npres_i, sfp1_los_i, sfp2_los_i;
    logic sfp1_npres_sync_o, sfp2_npres_sync_o, sfp1_los_sync_o, sfp2_los_sync_o;

    // Stimulus bundles and their delayed reference copies
    logic [45:0] flash_ctl_in, flash_ctl_out, flash_ctl_d1;
    logic [24:0] pad_in, pad_sync_out, pad_in_d1, pad_in_d2;
    logic [9:0] drive_in, drive_out, drive_d1;
    logic pin_check_en;
    integer seed;
    int cycle_count = 0;
    // Command stream as the ICAP pins see it, each byte bit-reversed
    logic [31:0] boot_words [6] = '{32'hffff_ffff, 32'h5599_aa66, 32'h0400_0000,
        32'h0c00_0180, 32'h0000_00f0, 32'h0400_0000};

    assign {flash_dq_i, flash_dq_oe_i, flash_addr_i, flash_region_i, flash_region_oe_i,
        flash_ce_n_i, flash_oe_n_i, flash_we_n_i, flash_adv_n_i} = flash_ctl_in;
    assign flash_ctl_out = {flash_dq_pad_o, flash_dq_oe_o, flash_addr_o, flash_region_o,
        flash_region_oe_o, flash_ce_n_o, flash_oe_n_o, flash_we_n_o, flash_adv_n_o};
    assign {flash_dq_pad_i, sfp1_npres_i, sfp2_npres_i, sfp1_los_i, sfp2_los_i, scl_sfp_pad_i,
        sda_sfp1_pad_i, sda_sfp2_pad_i, scl_eeprom_pad_i, sda_eeprom_pad_i} = pad_in;
    assign pad_sync_out = {flash_dq_o, sfp1_npres_sync_o, sfp2_npres_sync_o, sfp1_los_sync_o,
        sfp2_los_sync_o, scl_sfp_sync_o, sda_sfp1_sync_o, sda_sfp2_sync_o,
        scl_eeprom_sync_o, sda_eeprom_sync_o};
    assign {scl_sfp_o_i, sda_sfp1_o_i, sda_sfp2_o_i, scl_eeprom_o_i, sda_eeprom_o_i,
        scl_sfp_t_i, sda_sfp1_t_i, sda_sfp2_t_i, scl_eeprom_t_i, sda_eeprom_t_i} = drive_in;
    assign drive_out = {scl_sfp_pad_o, sda_sfp1_pad_o, sda_sfp2_pad_o, scl_eeprom_pad_o,
        sda_eeprom_pad_o, scl_sfp_pad_t_o, sda_sfp1_pad_t_o, sda_sfp2_pad_t_o,
        scl_eeprom_pad_t_o, sda_eeprom_pad_t_o};

    board_glue_top u_dut (.*);

    always #(clk_period / 2) pcie_user_clk = ~pcie_user_clk;

    task automatic report_mismatch(input string test_name, input logic [63:0] expected,
            input logic [63:0] actual);
        $display("mismatch %s: expected %h, actual %h", test_name, expected, actual);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // Shift-register reference models and the run limit
    always @(posedge pcie_user_clk) begin
        flash_ctl_d1 <= flash_ctl_in;
        pad_in_d1 <= pad_in;
        pad_in_d2 <= pad_in_d1;
        drive_d1 <= drive_in;
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    always @(negedge pcie_user_clk) begin
        if (pin_check_en) begin
            assert (flash_ctl_out === flash_ctl_d1)
                else report_mismatch("flash_out", 64'(flash_ctl_d1), 64'(flash_ctl_out));
            assert (pad_sync_out === pad_in_d2)
                else report_mismatch("pad_sync", 64'(pad_in_d2), 64'(pad_sync_out));
            assert (drive_out === drive_d1)
                else report_mismatch("drive_out", 64'(drive_d1), 64'(drive_out));
        end
        // Idle ICAP always shows the dummy word
        if (!rst_i && icap_csib_o === 1'b1) begin
            assert (icap_data_o === 32'hffff_ffff)
                else report_mismatch("idle_word", 64'hffff_ffff, 64'(icap_data_o));
        end
    end

    assert property (@(negedge pcie_user_clk) icap_rdwrb_o === 1'b0)
        else report_mismatch("rdwrb", 64'd0, 64'(icap_rdwrb_o));

    // Called just after a rising edge; request is sampled at the next edge
    task automatic run_boot_request(input logic avail);
        int latency = 0;
        boot_req_i = 1'b1;
        icap_avail_i = avail;
        @(posedge pcie_user_clk);
        #1 boot_req_i = 1'b0;
        while (icap_csib_o !== 1'b0 && latency < 8) begin
            @(posedge pcie_user_clk);
            #1 latency++;
        end
        if (avail) begin
            assert (latency == 3)
                else report_mismatch("boot_latency", 64'd3, 64'(latency));
            for (int i = 0; i < 6; i++) begin
                assert (icap_csib_o === 1'b0)
                    else report_mismatch("boot_csib", 64'd0, 64'(icap_csib_o));
                assert (icap_data_o === boot_words[i])
                    else report_mismatch("boot_word", 64'(boot_words[i]), 64'(icap_data_o));
                @(posedge pcie_user_clk);
                #1;
            end
            assert (icap_csib_o === 1'b1)
                else report_mismatch("boot_end", 64'd1, 64'(icap_csib_o));
        end else begin
            assert (latency == 8)
                else report_failure("chip select went low while icap_avail_i was low");
        end
        icap_avail_i = 1'b0;
    endtask

    initial begin
        seed = 32'h5aaa;
        rst_i = 1'b1;
        boot_req_i = 1'b0;
        icap_avail_i = 1'b0;
        pin_check_en = 1'b0;
        // Inputs held opposite to the reset values
        flash_ctl_in = {16'h0, 1'b1, 23'h0, 1'b0, 1'b1, 4'h0};
        pad_in = '1;
        drive_in = 10'h3e0;
        repeat (reset_cycles) @(posedge pcie_user_clk);
        #1;
        assert ({icap_csib_o, icap_data_o} === {1'b1, 32'hffff_ffff})
            else report_mismatch("reset_icap", 64'h1_ffff_ffff, 64'({icap_csib_o, icap_data_o}));
        assert (flash_ctl_out[3:0] === 4'hf)
            else report_mismatch("reset_strobes", 64'hf, 64'(flash_ctl_out[3:0]));
        assert ({flash_dq_oe_o, flash_region_oe_o} === 2'b00)
            else report_mismatch("reset_oe", 64'd0, 64'({flash_dq_oe_o, flash_region_oe_o}));
        assert (drive_out[4:0] === 5'h1f)
            else report_mismatch("reset_release", 64'h1f, 64'(drive_out[4:0]));
        rst_i = 1'b0;
        repeat (2) @(posedge pcie_user_clk);
        #1 pin_check_en = 1'b1;
        repeat (random_cycles) begin
            flash_ctl_in = 46'({$random(seed), $random(seed)});
            pad_in = 25'($random(seed));
            drive_in = 10'($random(seed));
            @(posedge pcie_user_clk);
            #1;
        end
        run_boot_request(1'b1);
        run_boot_request(1'b0);
        repeat (4) @(posedge pcie_user_clk);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
board_pkg.sv
sync_signal_bank.sv
icap_reboot_seq.sv
flash_pin_stage.sv
sfp_i2c_pin_stage.sv
board_glue_top.sv
tb_board_glue.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only if the pass line appears
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_board_glue -f verilog.f -o tb_board_glue
./obj_dir/tb_board_glue | tee /dev/stderr | grep -qx "Test OK"
echo "simulation passed"
